/* tb.f */
source/cpu_pkg.sv
source/control_unit.sv
source/register_file.sv
source/alu.sv
source/fetch_unit.sv
source/memory_port.sv
source/cpu_top.sv
sim/tb_memory.sv
sim/cpu_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= cpu_tb
FILELIST ?= tb.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
FAIL_TEXT ?= TEST FAILED
PASS_TEXT ?= TEST PASSED
VFLAGS ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run lint clean

all: run

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_TEXT)" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "$(PASS_TEXT)" $(LOG) || { echo "Simulation gave no result, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* sim/cpu_tb.sv */
`timescale 1ns/1ns

module cpu_tb;
    import cpu_pkg::*;

    typedef struct packed {
        logic is_write;
        logic is_load;       // Data read of a Load
        logic write_back;    // Store right after a Load
        word_t addr;
        word_t data;
    } access_t;

    logic clock;
    logic reset;
    mem_req_t mem_req;
    mem_rsp_t mem_rsp;
    int image_len;
    access_t expected [$];
    word_t loaded_word;
    logic all_seen = 1'b0;
    int errors = 0;
    int accesses = 0;
    int cycles = 0;
    int cycle_limit;

    cpu_top DUT (.*);

    tb_memory mem_model (.*);

    initial
    begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    // Instruction-level model with one entry per memory access in order
    task automatic build_expected();
        word_t r [reg_count];
        word_t m [256];
        word_t w;
        word_t imm;
        word_t addr;
        logic [1:0] a;
        logic [1:0] b;
        logic after_load;
        after_load = 1'b0;
        for (int i = 0; i < 256; i++)
            m[i] = mem_model.mem[i];
        for (int i = 0; i < reg_count; i++)
            r[i] = '0;
        for (int pc = 0; pc < image_len; pc++)
        begin
            w = m[pc];
            a = w[7:6];
            b = w[1:0];
            imm = {10'b0, w[5:0]};
            expected.push_back(access_t'{1'b0, 1'b0, 1'b0, word_t'(pc), w});
            case (w[15:12])
                op_mov: r[a] = r[b];
                op_movi: r[a] = imm;
                op_add: r[a] = r[a] + r[b];
                op_addi: r[a] = r[a] + imm;
                op_sub: r[a] = r[a] - r[b];
                op_subi: r[a] = r[a] - imm;
                op_not: r[a] = ~r[a];
                op_and: r[a] = r[a] & r[b];
                op_or: r[a] = r[a] | r[b];
                op_xor: r[a] = r[a] ^ r[b];
                op_xnor: r[a] = ~(r[a] ^ r[b]);
                op_load:
                begin
                    addr = r[a];
                    r[b] = m[addr[7:0]];
                    expected.push_back(access_t'{1'b0, 1'b1, 1'b0, addr, r[b]});
                end
                op_store:
                begin
                    addr = r[b];
                    expected.push_back(access_t'{1'b1, 1'b0, after_load, addr, r[a]});
                    m[addr[7:0]] = r[a];
                end
                default: ;    // Fetch only
            endcase
            after_load = (w[15:12] == op_load);
        end
    endtask

    task automatic check_access();
        access_t e;
        e = expected.pop_front();
        accesses++;
        assert (mem_req.write == e.is_write && mem_req.addr == e.addr)
        else
        begin
            errors++;
            $display("Fail %0t: write=%b addr %h, model expects write=%b addr %h",
                $time, mem_req.write, mem_req.addr, e.is_write, e.addr);
        end
        assert (!e.is_write || (mem_req.wdata == e.data
            && (!e.write_back || mem_req.wdata == loaded_word)))
        else
        begin
            errors++;
            $display("Fail %0t: stored %h at %h, model %h, last load returned %h",
                $time, mem_req.wdata, mem_req.addr, e.data, loaded_word);
        end
        if (e.is_load)
            loaded_word = mem_rsp.rdata;
        all_seen = (expected.size() == 0);
    endtask

    always @(posedge clock)
    begin
        cycles++;
        if (!reset && !all_seen && mem_req.valid && mem_rsp.done)
            check_access();
    end

    assert property (@(posedge clock) reset |-> !mem_req.valid)
    else
    begin
        errors++;
        $display("Memory request raised during reset at %0t", $time);
    end

    // Request frozen while memory stalls
    assert property (@(posedge clock) disable iff (reset)
        mem_req.valid && !mem_rsp.done |=> $stable(mem_req))
    else
    begin
        errors++;
        $display("Fail %0t: request changed before completion", $time);
    end

    initial
    begin
        reset = 1'b1;
        repeat (16) @(posedge clock);
        build_expected();
        cycle_limit = (image_len + 4) * 2 * 8;
        @(negedge clock);
        reset = 1'b0;
        while (!all_seen && cycles < cycle_limit)
            @(negedge clock);
        if (!all_seen)
        begin
            errors++;
            $display("Run stopped after %0d cycles with %0d accesses never seen",
                cycles, expected.size());
        end
        $display("Accesses checked %0d, errors %0d", accesses, errors);
        if (errors == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

/* sim/tb_memory.sv */
`timescale 1ns/1ns

module tb_memory (
    input logic clock,
    input logic reset,
    input cpu_pkg::mem_req_t mem_req,
    output cpu_pkg::mem_rsp_t mem_rsp,
    output int image_len
);
    import cpu_pkg::*;

    // Word layout is opcode, param1, param2 from the top
    localparam int image_words = 31;
    localparam word_t image [image_words] = '{
        16'ha02b, 16'ha055, 16'ha8bc, 16'ha0f0,    // movi r0..r3, r2 through param1 6'h22
        16'hc003, 16'hc043, 16'hc083,              // store r0, r1, r2 at [r3]
        16'h1001, 16'hc003, 16'h3042, 16'hc043,    // add r0 r1, sub r1 r2
        16'h5080, 16'hc083, 16'h6001, 16'hc003,    // not r2, and r0 r1
        16'h7042, 16'hc043, 16'h8080, 16'hc083,    // or r1 r2, xor r2 r0
        16'h9001, 16'hc003, 16'h207f, 16'hc043,    // xnor r0 r1, addi r1 6'h3f
        16'h40a5, 16'hc083, 16'h0002, 16'hc003,    // subi r2 6'h25, mov r0 r2
        16'hb0c1, 16'hc043,                        // load r1 from [r3], store it back
        16'hd000, 16'hf555                         // Unknown opcodes
    };

    word_t mem [256];
    integer seed = 32'h928e_9d04;
    int wait_left;
    logic armed;

    assign image_len = image_words;

    initial
    begin
        for (int i = 0; i < 256; i++)
            mem[i] = (i < image_words) ? image[i] : {8'hf0, 8'(i) ^ 8'h5a};    // Fill is unknown op
    end

    // Completion 0 to 3 cycles after the request shows up
    always @(negedge clock or posedge reset)
    begin
        if (reset)
        begin
            mem_rsp <= '0;
            armed = 1'b0;
            wait_left = 0;
        end
        else
        begin
            mem_rsp.done <= 1'b0;
            if (mem_req.valid && !mem_rsp.done)
            begin
                if (!armed)
                begin
                    wait_left = int'($unsigned($random(seed)) % 4);
                    armed = 1'b1;
                end
                if (wait_left == 0)
                begin
                    armed = 1'b0;
                    mem_rsp.done <= 1'b1;
                    if (mem_req.write)
                        mem[mem_req.addr[7:0]] = mem_req.wdata;
                    else
                        mem_rsp.rdata <= mem[mem_req.addr[7:0]];
                end
                else
                    wait_left = wait_left - 1;
            end
        end
    end

endmodule

/* source/cpu_top.sv */
`timescale 1ns/1ns

module cpu_top (
    input logic clock,
    input logic reset,
    output cpu_pkg::mem_req_t mem_req,
    input cpu_pkg::mem_rsp_t mem_rsp
);
    import cpu_pkg::*;

    ctrl_t ctrl;
    instr_t instr;
    word_t pc;
    word_t rd_a;
    word_t rd_b;
    word_t alu_result;
    word_t wr_data;
    word_t read_data;
    word_t mem_addr;
    reg_idx_t wr_idx;
    logic mem_complete;

    control_unit u_control (
        .clock(clock),
        .reset(reset),
        .instr(instr),
        .mem_complete(mem_complete),
        .ctrl(ctrl)
    );

    fetch_unit u_fetch (
        .clock(clock),
        .reset(reset),
        .ir_load(ctrl.ir_load),
        .pc_step(ctrl.pc_step),
        .fetched(read_data),
        .pc(pc),
        .instr(instr)
    );

    // Load takes param2 as destination, all others param1
    assign wr_idx = (ctrl.write_sel == wsel_mem) ? instr.param2[1:0] : instr.param1[1:0];

    register_file u_regs (
        .clock(clock),
        .reset(reset),
        .rd_a_idx(instr.param1[1:0]),
        .rd_b_idx(instr.param2[1:0]),
        .wr_idx(wr_idx),
        .wr_en(ctrl.reg_write),
        .wr_data(wr_data),
        .rd_a(rd_a),
        .rd_b(rd_b)
    );

    alu u_alu (
        .op(ctrl.alu_op),
        .use_imm(ctrl.alu_imm),
        .a(rd_a),
        .b_reg(rd_b),
        .imm(instr.param2),
        .result(alu_result)
    );

    always_comb
    begin
        case (ctrl.write_sel)
            wsel_alu: wr_data = alu_result;
            wsel_imm: wr_data = {{(word_w-field_w){1'b0}}, instr.param2};
            wsel_reg: wr_data = rd_b;
            default: wr_data = read_data;
        endcase
    end

    // Store addresses through param2, load through param1
    assign mem_addr = ctrl.pc_addr ? pc : (ctrl.mem_write ? rd_b : rd_a);

    memory_port u_mem_port (
        .clock(clock),
        .reset(reset),
        .start(ctrl.mem_start),
        .write(ctrl.mem_write),
        .addr(mem_addr),
        .wdata(rd_a),
        .mem_req(mem_req),
        .mem_rsp(mem_rsp),
        .mem_complete(mem_complete),
        .read_data(read_data)
    );

endmodule

/* source/memory_port.sv */
`timescale 1ns/1ns

module memory_port (
    input logic clock,
    input logic reset,
    input logic start,
    input logic write,
    input cpu_pkg::word_t addr,
    input cpu_pkg::word_t wdata,
    output cpu_pkg::mem_req_t mem_req,
    input cpu_pkg::mem_rsp_t mem_rsp,
    output logic mem_complete,
    output cpu_pkg::word_t read_data
);
    import cpu_pkg::*;

    logic req_valid;
    logic req_write;
    word_t mar;
    word_t mdr;

    always_ff @(posedge clock or posedge reset)
    begin
        if (reset)
        begin
            req_valid <= 1'b0;
            req_write <= 1'b0;
        end
        else if (start)
        begin
            req_valid <= 1'b1;
            req_write <= write;
        end
        else if (req_valid && mem_rsp.done)
        begin
            req_valid <= 1'b0;
        end
    end

    always_ff @(posedge clock)
    begin
        if (start)
        begin
            mar <= addr;
            mdr <= wdata;
        end
    end

    assign mem_req.valid = req_valid;
    assign mem_req.write = req_write;
    assign mem_req.addr = mar;
    assign mem_req.wdata = mdr;

    assign mem_complete = req_valid && mem_rsp.done;
    assign read_data = mem_rsp.rdata;    // Valid in the done cycle of a read

    // Request held steady while memory stalls
    assert property (@(posedge clock) disable iff (reset)
        mem_req.valid && !mem_rsp.done |=> mem_req.valid && $stable(mem_req.addr)
            && $stable(mem_req.write) && $stable(mem_req.wdata));

    assert property (@(posedge clock) disable iff (reset)
        mem_rsp.done |-> mem_req.valid);

endmodule

/* source/fetch_unit.sv */
`timescale 1ns/1ns

module fetch_unit (
    input logic clock,
    input logic reset,
    input logic ir_load,
    input logic pc_step,
    input cpu_pkg::word_t fetched,
    output cpu_pkg::word_t pc,
    output cpu_pkg::instr_t instr
);
    import cpu_pkg::*;

    always_ff @(posedge clock or posedge reset)
    begin
        if (reset)
        begin
            pc <= '0;
        end
        else if (pc_step)
        begin
            pc <= pc + word_t'(1);    // Word addressed
        end
    end

    always_ff @(posedge clock or posedge reset)
    begin
        if (reset)
        begin
            instr <= '0;
        end
        else if (ir_load)
        begin
            instr <= instr_t'(fetched);
        end
    end

endmodule

/* source/alu.sv */
`timescale 1ns/1ns

module alu (
    input cpu_pkg::alu_op_e op,
    input logic use_imm,
    input cpu_pkg::word_t a,
    input cpu_pkg::word_t b_reg,
    input logic [cpu_pkg::field_w-1:0] imm,
    output cpu_pkg::word_t result
);
    import cpu_pkg::*;

    word_t b;

    assign b = use_imm ? {{(word_w-field_w){1'b0}}, imm} : b_reg;    // Zero-extended immediate

    always_comb
    begin
        case (op)
            alu_add: result = a + b;
            alu_sub: result = a - b;
            alu_not: result = ~a;
            alu_and: result = a & b;
            alu_or: result = a | b;
            alu_xor: result = a ^ b;
            alu_xnor: result = ~(a ^ b);
            default: result = '0;
        endcase
    end

endmodule

/* source/register_file.sv */
`timescale 1ns/1ns

module register_file (
    input logic clock,
    input logic reset,
    input cpu_pkg::reg_idx_t rd_a_idx,
    input cpu_pkg::reg_idx_t rd_b_idx,
    input cpu_pkg::reg_idx_t wr_idx,
    input logic wr_en,
    input cpu_pkg::word_t wr_data,
    output cpu_pkg::word_t rd_a,
    output cpu_pkg::word_t rd_b
);
    import cpu_pkg::*;

    word_t regs [reg_count];

    always_ff @(posedge clock or posedge reset)
    begin
        if (reset)
        begin
            for (int i = 0; i < reg_count; i++)
                regs[i] <= '0;
        end
        else if (wr_en)
        begin
            regs[wr_idx] <= wr_data;
        end
    end

    assign rd_a = regs[rd_a_idx];
    assign rd_b = regs[rd_b_idx];

endmodule

/* source/control_unit.sv */
`timescale 1ns/1ns

module control_unit (
    input logic clock,
    input logic reset,
    input cpu_pkg::instr_t instr,
    input logic mem_complete,
    output cpu_pkg::ctrl_t ctrl
);
    import cpu_pkg::*;

    state_e state;
    state_e next_state;
    logic run;          // Low only until the first edge after reset
    logic busy;         // Access issued and not yet complete
    logic dec_write;
    wsel_e dec_wsel;
    alu_op_e dec_alu_op;
    logic dec_imm;
    logic in_op;

    always_ff @(posedge clock or posedge reset)
    begin
        if (reset)
        begin
            state <= st_fetch;
            run <= 1'b0;
            busy <= 1'b0;
        end
        else
        begin
            state <= next_state;
            run <= 1'b1;
            if (ctrl.mem_start)
                busy <= 1'b1;
            else if (mem_complete)
                busy <= 1'b0;
        end
    end

    always_comb
    begin
        next_state = state;
        case (state)
            st_fetch:
                if (mem_complete)
                    next_state = st_decode;
            st_decode:
                case (instr.opcode)
                    op_load, op_store: next_state = st_mem_access;
                    op_mov, op_movi, op_add, op_addi, op_sub, op_subi,
                    op_not, op_and, op_or, op_xor, op_xnor: next_state = st_execute;
                    default: next_state = st_fetch;    // Unknown opcode skipped
                endcase
            st_execute:
                next_state = st_fetch;
            st_mem_access:
                if (mem_complete)
                    next_state = st_fetch;
            default:
                next_state = st_fetch;
        endcase
    end

    // Opcode to datapath function
    always_comb
    begin
        dec_write = 1'b1;
        dec_wsel = wsel_alu;
        dec_alu_op = alu_add;
        dec_imm = 1'b0;
        case (instr.opcode)
            op_mov: dec_wsel = wsel_reg;
            op_movi: dec_wsel = wsel_imm;
            op_add: dec_alu_op = alu_add;
            op_addi:
            begin
                dec_alu_op = alu_add;
                dec_imm = 1'b1;
            end
            op_sub: dec_alu_op = alu_sub;
            op_subi:
            begin
                dec_alu_op = alu_sub;
                dec_imm = 1'b1;
            end
            op_not: dec_alu_op = alu_not;
            op_and: dec_alu_op = alu_and;
            op_or: dec_alu_op = alu_or;
            op_xor: dec_alu_op = alu_xor;
            op_xnor: dec_alu_op = alu_xnor;
            op_load: dec_wsel = wsel_mem;    // Written on completion only
            default: dec_write = 1'b0;
        endcase
    end

    assign in_op = (state == st_execute) || (state == st_mem_access);

    always_comb
    begin
        ctrl.reg_write = ((state == st_execute) && dec_write)
            || ((state == st_mem_access) && mem_complete && (instr.opcode == op_load));
        ctrl.write_sel = in_op ? dec_wsel : wsel_alu;
        ctrl.alu_op = in_op ? dec_alu_op : alu_add;
        ctrl.alu_imm = in_op && dec_imm;
        ctrl.mem_start = run && !busy && ((state == st_fetch) || (state == st_mem_access));
        ctrl.mem_write = (state == st_mem_access) && (instr.opcode == op_store);
        ctrl.pc_addr = run && (state == st_fetch);
        ctrl.ir_load = (state == st_fetch) && mem_complete;
        ctrl.pc_step = (state == st_fetch) && mem_complete;
    end

    // Waiting in fetch or mem_access allows no second request
    assert property (@(posedge clock) disable iff (reset)
        run && !mem_complete && ((state == st_fetch) || (state == st_mem_access))
            |=> !ctrl.mem_start);

    // Completions only answer an issued request
    assert property (@(posedge clock) disable iff (reset)
        mem_complete |-> busy);

endmodule

/* source/cpu_pkg.sv */
package cpu_pkg;

    localparam int word_w = 16;
    localparam int field_w = 6;
    localparam int reg_count = 4;

    typedef logic [word_w-1:0] word_t;
    typedef logic [1:0] reg_idx_t;

    typedef enum logic [3:0] {
        op_mov   = 4'd0,
        op_add   = 4'd1,
        op_addi  = 4'd2,
        op_sub   = 4'd3,
        op_subi  = 4'd4,
        op_not   = 4'd5,
        op_and   = 4'd6,
        op_or    = 4'd7,
        op_xor   = 4'd8,
        op_xnor  = 4'd9,
        op_movi  = 4'd10,
        op_load  = 4'd11,
        op_store = 4'd12
    } opcode_e;

    typedef enum logic [2:0] {
        alu_add  = 3'd0,
        alu_sub  = 3'd1,
        alu_not  = 3'd2,
        alu_and  = 3'd3,
        alu_or   = 3'd4,
        alu_xor  = 3'd5,
        alu_xnor = 3'd6
    } alu_op_e;

    // Register write source
    typedef enum logic [1:0] {
        wsel_alu = 2'd0,
        wsel_imm = 2'd1,
        wsel_reg = 2'd2,
        wsel_mem = 2'd3
    } wsel_e;

    typedef struct packed {
        opcode_e opcode;
        logic [field_w-1:0] param1;
        logic [field_w-1:0] param2;
    } instr_t;

    typedef enum logic [1:0] {
        st_fetch      = 2'd0,
        st_decode     = 2'd1,
        st_execute    = 2'd2,
        st_mem_access = 2'd3
    } state_e;

    typedef struct packed {
        logic reg_write;
        wsel_e write_sel;
        alu_op_e alu_op;
        logic alu_imm;
        logic mem_start;
        logic mem_write;
        logic pc_addr;    // Memory address from PC
        logic ir_load;
        logic pc_step;
    } ctrl_t;

    typedef struct packed {
        logic valid;
        logic write;
        word_t addr;
        word_t wdata;
    } mem_req_t;

    typedef struct packed {
        logic done;
        word_t rdata;
    } mem_rsp_t;

endpackage
